//--- compile.f
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/decoder.sv
hw/inst_queue.sv
hw/dispatch_reg.sv
hw/decode_stage_top.sv
tests/decode_stage_sva.sv
tests/decode_stage_tb.sv

//--- hw/decode_pkg.sv
package decode_pkg;

  localparam int NUM_SLOTS = 2;

  typedef logic [63:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam reg_idx_t ZERO_REG = 5'd31;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rega_idx;
      reg_idx_t    regb_idx;
      logic [15:0] mem_disp;
    } m;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] func;
    } p;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rega_idx;
      reg_idx_t    regb_idx;
      logic [2:0]  sbz;
      logic        imm;
      logic [6:0]  func;
      reg_idx_t    regc_idx;
    } r;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rega_idx;
      logic [7:0]  lit;
      logic        imm;
      logic [6:0]  func;
      reg_idx_t    regc_idx;
    } i;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rega_idx;
      logic [20:0] branch_disp;
    } b;
  } inst_t;

  // primary opcodes
  localparam logic [5:0] PAL_INST  = 6'h00;
  localparam logic [5:0] LDA_INST  = 6'h08;
  localparam logic [5:0] INTA_GRP  = 6'h10;
  localparam logic [5:0] INTL_GRP  = 6'h11;
  localparam logic [5:0] INTS_GRP  = 6'h12;
  localparam logic [5:0] INTM_GRP  = 6'h13;
  localparam logic [5:0] JSR_GRP   = 6'h1a;
  localparam logic [5:0] LDQ_INST  = 6'h29;
  localparam logic [5:0] STQ_INST  = 6'h2d;
  localparam logic [5:0] BR_INST   = 6'h30;
  localparam logic [5:0] BSR_INST  = 6'h34;
  localparam logic [5:0] BLBC_INST = 6'h38;
  localparam logic [5:0] BEQ_INST  = 6'h39;
  localparam logic [5:0] BLT_INST  = 6'h3a;
  localparam logic [5:0] BLE_INST  = 6'h3b;
  localparam logic [5:0] BLBS_INST = 6'h3c;
  localparam logic [5:0] BNE_INST  = 6'h3d;
  localparam logic [5:0] BGE_INST  = 6'h3e;
  localparam logic [5:0] BGT_INST  = 6'h3f;

  // operate-format function codes, per group
  localparam logic [6:0] ADDQ_INST   = 7'h20;  // INTA
  localparam logic [6:0] SUBQ_INST   = 7'h29;
  localparam logic [6:0] CMPEQ_INST  = 7'h2d;
  localparam logic [6:0] CMPULT_INST = 7'h1d;
  localparam logic [6:0] CMPULE_INST = 7'h3d;
  localparam logic [6:0] CMPLT_INST  = 7'h4d;
  localparam logic [6:0] CMPLE_INST  = 7'h6d;
  localparam logic [6:0] AND_INST    = 7'h00;  // INTL
  localparam logic [6:0] BIC_INST    = 7'h08;
  localparam logic [6:0] BIS_INST    = 7'h20;
  localparam logic [6:0] ORNOT_INST  = 7'h28;
  localparam logic [6:0] XOR_INST    = 7'h40;
  localparam logic [6:0] EQV_INST    = 7'h48;
  localparam logic [6:0] SRL_INST    = 7'h34;  // INTS
  localparam logic [6:0] SLL_INST    = 7'h39;
  localparam logic [6:0] SRA_INST    = 7'h3c;
  localparam logic [6:0] MULQ_INST   = 7'h20;  // INTM

  // PAL function field is the full 26 bits
  localparam logic [25:0] PAL_HALT  = 26'h555;
  localparam logic [25:0] PAL_WHAMI = 26'h03c;

  localparam inst_t NOOP_INST = 32'h47ff041f;  // bis r31,r31,r31

  // five units, so three bits
  typedef enum logic [2:0] {FU_ALU, FU_MULT, FU_LD, FU_ST, FU_BR} fu_e;

  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ, ALU_CMPEQ, ALU_CMPULT, ALU_CMPLE, ALU_CMPLT, ALU_CMPULE,
    ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ
  } alu_func_e;

  typedef enum logic [1:0] {OPA_IS_REGA, OPA_IS_MEM_DISP, OPA_IS_NPC, OPA_IS_NOT3} opa_sel_e;
  typedef enum logic [1:0] {OPB_IS_REGB, OPB_IS_ALU_IMM, OPB_IS_BR_DISP} opb_sel_e;

  typedef struct packed {
    addr_t                 pc;    // pc of slot 0
    inst_t [NUM_SLOTS-1:0] inst;
  } fetch_bundle_t;

  typedef struct packed {
    logic      valid;
    logic      illegal;
    logic      halt;
    logic      cpuid;
    fu_e       fu;
    alu_func_e func;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    reg_idx_t  dest_idx;
    reg_idx_t  rega_idx;
    reg_idx_t  regb_idx;
    logic      rd_mem;
    logic      wr_mem;
    logic      cond_branch;
    logic      uncond_branch;
    addr_t     pc;
    addr_t     npc;
    addr_t     target;
    inst_t     inst;
  } decoded_inst_t;

  typedef decoded_inst_t [NUM_SLOTS-1:0] decoded_bundle_t;

endpackage

//--- hw/decode_stage_top.sv
`timescale 1ns/10ps

module decode_stage_top import decode_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clock,
  input  logic            arst_n,
  input  logic            fetch_valid,
  input  fetch_bundle_t   fetch_bundle,
  output logic            fetch_ready,
  output logic            disp_valid,
  output decoded_bundle_t disp_bundle,
  input  logic            disp_ready
);

  logic            head_valid;
  fetch_bundle_t   head_bundle;
  logic            pop;
  decoded_bundle_t dec_bundle;

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) inst_queue_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .in_valid    (fetch_valid),
    .in_bundle   (fetch_bundle),
    .in_ready    (fetch_ready),
    .head_valid  (head_valid),
    .head_bundle (head_bundle),
    .pop         (pop)
  );

  decoder decoder_i (
    .bundle_valid (head_valid),
    .bundle       (head_bundle),
    .dec_bundle   (dec_bundle)
  );

  dispatch_reg dispatch_reg_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .in_valid   (head_valid),
    .in_bundle  (dec_bundle),
    .pop        (pop),
    .out_valid  (disp_valid),
    .out_bundle (disp_bundle),
    .out_ready  (disp_ready)
  );

endmodule

//--- hw/decoder.sv
`timescale 1ns/10ps

module decoder import decode_pkg::*; (
  input  logic            bundle_valid,
  input  fetch_bundle_t   bundle,
  output decoded_bundle_t dec_bundle
);

  addr_t [NUM_SLOTS-1:0] slot_pc;

  for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
    assign slot_pc[k] = bundle.pc + addr_t'(4 * k);  // slots are consecutive words

    inst_decoder inst_decoder_i (
      .valid_in (bundle_valid),  // shared by both slots
      .inst_in  (bundle.inst[k]),
      .pc       (slot_pc[k]),
      .decoded  (dec_bundle[k])
    );
  end

endmodule

//--- hw/dispatch_reg.sv
`timescale 1ns/10ps

module dispatch_reg import decode_pkg::*; (
  input  logic            clock,
  input  logic            arst_n,
  input  logic            in_valid,
  input  decoded_bundle_t in_bundle,
  output logic            pop,
  output logic            out_valid,
  output decoded_bundle_t out_bundle,
  input  logic            out_ready
);

  logic can_load;  // empty, or current bundle leaves this edge
  logic has_halt;
  logic halted;    // sticky until reset

  assign can_load = ~out_valid | out_ready;
  assign pop      = in_valid & can_load & ~halted;

  always_comb begin
    has_halt = 1'b0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      has_halt = has_halt | in_bundle[k].halt;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      halted    <= 1'b0;
    end else begin
      if (can_load) out_valid <= pop;
      if (pop && has_halt) halted <= 1'b1;  // this bundle still goes out
    end
  end

  always_ff @(posedge clock) begin
    if (pop) out_bundle <= in_bundle;
  end

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder import decode_pkg::*; (
  input  logic          valid_in,
  input  inst_t         inst_in,
  input  addr_t         pc,
  output decoded_inst_t decoded
);

  addr_t npc;
  addr_t br_target;
  logic  op_grp;  // any of the four integer operate groups

  assign npc       = pc + addr_t'(4);
  assign br_target = npc + {{41{inst_in.b.branch_disp[20]}}, inst_in.b.branch_disp, 2'b00};
  assign op_grp    = inst_in.r.opcode inside {INTA_GRP, INTL_GRP, INTS_GRP, INTM_GRP};

  always_comb begin
    // no-op defaults
    decoded.valid         = 1'b0;
    decoded.illegal       = 1'b0;
    decoded.halt          = 1'b0;
    decoded.cpuid         = 1'b0;
    decoded.fu            = FU_ALU;
    decoded.func          = ALU_ADDQ;
    decoded.opa_sel       = OPA_IS_REGA;
    decoded.opb_sel       = OPB_IS_REGB;
    decoded.dest_idx      = ZERO_REG;
    decoded.rega_idx      = ZERO_REG;
    decoded.regb_idx      = ZERO_REG;
    decoded.rd_mem        = 1'b0;
    decoded.wr_mem        = 1'b0;
    decoded.cond_branch   = 1'b0;
    decoded.uncond_branch = 1'b0;
    decoded.pc            = pc;
    decoded.npc           = npc;
    decoded.target        = npc;
    decoded.inst          = NOOP_INST;

    if (valid_in) begin
      decoded.valid = 1'b1;
      decoded.inst  = inst_in;

      if (op_grp) begin
        decoded.opb_sel  = inst_in.r.imm ? OPB_IS_ALU_IMM : OPB_IS_REGB;
        decoded.dest_idx = inst_in.r.regc_idx;
        decoded.rega_idx = inst_in.r.rega_idx;
        decoded.regb_idx = inst_in.r.imm ? ZERO_REG : inst_in.r.regb_idx;  // literal form
      end

      case (inst_in.m.opcode)
        PAL_INST: begin
          if (inst_in.p.func == PAL_HALT) begin
            decoded.halt = 1'b1;
          end else if (inst_in.p.func == PAL_WHAMI) begin
            decoded.cpuid    = 1'b1;
            decoded.dest_idx = inst_in.r.rega_idx;
          end else begin
            decoded.illegal = 1'b1;
            decoded.valid   = 1'b0;
          end
        end
        LDA_INST: begin
          decoded.opa_sel  = OPA_IS_MEM_DISP;
          decoded.dest_idx = inst_in.m.rega_idx;
          decoded.regb_idx = inst_in.m.regb_idx;  // base register
        end
        INTA_GRP: begin
          case (inst_in.r.func)
            ADDQ_INST:   decoded.func = ALU_ADDQ;
            SUBQ_INST:   decoded.func = ALU_SUBQ;
            CMPEQ_INST:  decoded.func = ALU_CMPEQ;
            CMPULT_INST: decoded.func = ALU_CMPULT;
            CMPULE_INST: decoded.func = ALU_CMPULE;
            CMPLT_INST:  decoded.func = ALU_CMPLT;
            CMPLE_INST:  decoded.func = ALU_CMPLE;
            default: begin
              decoded.illegal = 1'b1;
              decoded.valid   = 1'b0;
            end
          endcase
        end
        INTL_GRP: begin
          case (inst_in.r.func)
            AND_INST:   decoded.func = ALU_AND;
            BIC_INST:   decoded.func = ALU_BIC;
            BIS_INST:   decoded.func = ALU_BIS;
            ORNOT_INST: decoded.func = ALU_ORNOT;
            XOR_INST:   decoded.func = ALU_XOR;
            EQV_INST:   decoded.func = ALU_EQV;
            default: begin
              decoded.illegal = 1'b1;
              decoded.valid   = 1'b0;
            end
          endcase
        end
        INTS_GRP: begin
          case (inst_in.r.func)
            SRL_INST: decoded.func = ALU_SRL;
            SLL_INST: decoded.func = ALU_SLL;
            SRA_INST: decoded.func = ALU_SRA;
            default: begin
              decoded.illegal = 1'b1;
              decoded.valid   = 1'b0;
            end
          endcase
        end
        INTM_GRP: begin
          decoded.fu = FU_MULT;
          if (inst_in.r.func == MULQ_INST) begin
            decoded.func = ALU_MULQ;
          end else begin
            decoded.illegal = 1'b1;
            decoded.valid   = 1'b0;
          end
        end
        LDQ_INST: begin
          decoded.opa_sel  = OPA_IS_MEM_DISP;
          decoded.fu       = FU_LD;
          decoded.rd_mem   = 1'b1;
          decoded.dest_idx = inst_in.m.rega_idx;
          decoded.regb_idx = inst_in.m.regb_idx;
        end
        STQ_INST: begin
          decoded.opa_sel  = OPA_IS_MEM_DISP;
          decoded.fu       = FU_ST;
          decoded.wr_mem   = 1'b1;
          decoded.rega_idx = inst_in.m.rega_idx;  // store data
          decoded.regb_idx = inst_in.m.regb_idx;
        end
        BR_INST, BSR_INST: begin
          decoded.opa_sel       = OPA_IS_NPC;
          decoded.opb_sel       = OPB_IS_BR_DISP;
          decoded.fu            = FU_BR;
          decoded.uncond_branch = 1'b1;
          decoded.dest_idx      = inst_in.b.rega_idx;  // link register
          decoded.target        = br_target;
        end
        BLBC_INST, BEQ_INST, BLT_INST, BLE_INST,
        BLBS_INST, BNE_INST, BGE_INST, BGT_INST: begin
          decoded.opa_sel     = OPA_IS_NPC;
          decoded.opb_sel     = OPB_IS_BR_DISP;
          decoded.fu          = FU_BR;
          decoded.cond_branch = 1'b1;
          decoded.rega_idx    = inst_in.b.rega_idx;
          decoded.target      = br_target;
        end
        JSR_GRP: begin
          // jmp, jsr, ret and jsr_co all jump to rb with low bits cleared
          decoded.opa_sel       = OPA_IS_NOT3;
          decoded.func          = ALU_AND;
          decoded.fu            = FU_BR;
          decoded.uncond_branch = 1'b1;
          decoded.dest_idx      = inst_in.m.rega_idx;
          decoded.regb_idx      = inst_in.m.regb_idx;
        end
        default: begin
          decoded.illegal = 1'b1;
          decoded.valid   = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- hw/inst_queue.sv
`timescale 1ns/10ps

module inst_queue import decode_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic          clock,
  input  logic          arst_n,
  input  logic          in_valid,
  input  fetch_bundle_t in_bundle,
  output logic          in_ready,
  output logic          head_valid,
  output fetch_bundle_t head_bundle,
  input  logic          pop
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  fetch_bundle_t    mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pull;

  assign in_ready    = (count != CNT_W'(QUEUE_DEPTH));
  assign head_valid  = (count != '0);
  assign head_bundle = mem[rd_ptr];
  assign push        = in_valid & in_ready;
  assign pull        = pop & head_valid;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pull) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr] <= in_bundle;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_stage_tb \
  -f compile.f -o decode_stage_sim

./obj_dir/decode_stage_sim

//--- tests/decode_stage_sva.sv
`timescale 1ns/10ps

module decode_stage_sva import decode_pkg::*; (
  input logic            clock,
  input logic            arst_n,
  input logic            fetch_valid,
  input fetch_bundle_t   fetch_bundle,
  input logic            fetch_ready,
  input logic            disp_valid,
  input decoded_bundle_t disp_bundle,
  input logic            disp_ready,
  input logic            pop
);

  logic disp_halt;  // halt bundle sits in the output register
  logic halt_seen;

  always_comb begin
    disp_halt = 1'b0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      disp_halt = disp_halt | disp_bundle[k].halt;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      halt_seen <= 1'b0;
    end else if (disp_valid && disp_halt) begin
      halt_seen <= 1'b1;
    end
  end

  disp_hold: assert property (@(posedge clock) disable iff (!arst_n)
    disp_valid && !disp_ready |=> disp_valid && $stable(disp_bundle))
    else $error("disp_valid or disp_bundle changed while stalled");

  fetch_hold: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_bundle))
    else $error("fetch_valid or fetch_bundle changed while stalled");

  no_pop_halted: assert property (@(posedge clock) disable iff (!arst_n)
    (halt_seen || (disp_valid && disp_halt)) |-> !pop)
    else $error("queue popped after halt");

  idle_after_reset: assert property (@(posedge clock) $rose(arst_n) |-> !disp_valid)
    else $error("disp_valid high right after reset release");

endmodule

bind decode_stage_top decode_stage_sva decode_stage_sva_i (
  .clock        (clock),
  .arst_n       (arst_n),
  .fetch_valid  (fetch_valid),
  .fetch_bundle (fetch_bundle),
  .fetch_ready  (fetch_ready),
  .disp_valid   (disp_valid),
  .disp_bundle  (disp_bundle),
  .disp_ready   (disp_ready),
  .pop          (pop)
);

//--- tests/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb import decode_pkg::*; ();

  localparam int QUEUE_DEPTH   = 4;
  localparam int RANDOM_CYCLES = 3000;
  localparam int WAIT_LIMIT    = 200;

  logic            clock;
  logic            arst_n;
  logic            fetch_valid;
  fetch_bundle_t   fetch_bundle;
  logic            fetch_ready;
  logic            disp_valid;
  decoded_bundle_t disp_bundle;
  logic            disp_ready;

  integer          seed;
  decoded_bundle_t exp_q[$];       // accepted, not yet dispatched
  logic            fetch_fire;
  logic            halt_pending;   // next new bundle carries a halt
  logic            halt_accepted;
  logic            halt_gone;      // halt bundle has left the stage
  int              after_halt;     // bundles accepted behind the halt
  int              waited;

  decode_stage_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) decode_stage_top_i (
    .clock        (clock),
    .arst_n       (arst_n),
    .fetch_valid  (fetch_valid),
    .fetch_bundle (fetch_bundle),
    .fetch_ready  (fetch_ready),
    .disp_valid   (disp_valid),
    .disp_bundle  (disp_bundle),
    .disp_ready   (disp_ready)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_decoded(input string name, input decoded_inst_t exp,
                               input decoded_inst_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // operate groups: which opcode/function pairs exist
  task automatic group_func(input logic [5:0] op, input logic [6:0] fn,
                            output alu_func_e f, output logic ok);
    ok = 1'b1;
    f  = ALU_ADDQ;
    case ({op, fn})
      {INTA_GRP, ADDQ_INST}:   f = ALU_ADDQ;
      {INTA_GRP, SUBQ_INST}:   f = ALU_SUBQ;
      {INTA_GRP, CMPEQ_INST}:  f = ALU_CMPEQ;
      {INTA_GRP, CMPULT_INST}: f = ALU_CMPULT;
      {INTA_GRP, CMPULE_INST}: f = ALU_CMPULE;
      {INTA_GRP, CMPLT_INST}:  f = ALU_CMPLT;
      {INTA_GRP, CMPLE_INST}:  f = ALU_CMPLE;
      {INTL_GRP, AND_INST}:    f = ALU_AND;
      {INTL_GRP, BIC_INST}:    f = ALU_BIC;
      {INTL_GRP, BIS_INST}:    f = ALU_BIS;
      {INTL_GRP, ORNOT_INST}:  f = ALU_ORNOT;
      {INTL_GRP, XOR_INST}:    f = ALU_XOR;
      {INTL_GRP, EQV_INST}:    f = ALU_EQV;
      {INTS_GRP, SRL_INST}:    f = ALU_SRL;
      {INTS_GRP, SLL_INST}:    f = ALU_SLL;
      {INTS_GRP, SRA_INST}:    f = ALU_SRA;
      {INTM_GRP, MULQ_INST}:   f = ALU_MULQ;
      default:                 ok = 1'b0;
    endcase
  endtask

  // reference decode of one word, straight from the raw bit fields
  task automatic ref_decode(input logic [31:0] w, input addr_t pc, output decoded_inst_t d);
    logic [5:0] op;
    logic       bad;
    logic       ok;
    alu_func_e  f;
    addr_t      disp;
    op   = w[31:26];
    bad  = 1'b0;
    disp = {{41{w[20]}}, w[20:0], 2'b00};
    d            = '0;
    d.valid      = 1'b1;
    d.fu         = FU_ALU;
    d.func       = ALU_ADDQ;
    d.opa_sel    = OPA_IS_REGA;
    d.opb_sel    = OPB_IS_REGB;
    d.dest_idx   = ZERO_REG;
    d.rega_idx   = ZERO_REG;
    d.regb_idx   = ZERO_REG;
    d.pc         = pc;
    d.npc        = pc + 64'd4;
    d.target     = pc + 64'd4;
    d.inst       = w;
    if (op[5:2] == 4'b0100) begin  // operate format, imm selects literal
      d.opb_sel  = w[12] ? OPB_IS_ALU_IMM : OPB_IS_REGB;
      d.dest_idx = w[4:0];
      d.rega_idx = w[25:21];
      d.regb_idx = w[12] ? ZERO_REG : w[20:16];
      group_func(op, w[11:5], f, ok);
      d.func = f;
      bad    = !ok;
      if (op == INTM_GRP) d.fu = FU_MULT;
    end else if (op == PAL_INST) begin
      if (w[25:0] == PAL_HALT) begin
        d.halt = 1'b1;
      end else if (w[25:0] == PAL_WHAMI) begin
        d.cpuid    = 1'b1;
        d.dest_idx = w[25:21];
      end else begin
        bad = 1'b1;
      end
    end else if (op == LDA_INST || op == LDQ_INST || op == STQ_INST) begin
      d.opa_sel  = OPA_IS_MEM_DISP;
      d.regb_idx = w[20:16];
      if (op == STQ_INST) begin
        d.fu       = FU_ST;
        d.wr_mem   = 1'b1;
        d.rega_idx = w[25:21];
      end else begin
        d.dest_idx = w[25:21];
        if (op == LDQ_INST) begin
          d.fu     = FU_LD;
          d.rd_mem = 1'b1;
        end
      end
    end else if (op == BR_INST || op == BSR_INST || op[5:3] == 3'b111) begin
      d.opa_sel = OPA_IS_NPC;
      d.opb_sel = OPB_IS_BR_DISP;
      d.fu      = FU_BR;
      d.target  = pc + 64'd4 + disp;
      if (op[5:3] == 3'b111) begin
        d.cond_branch = 1'b1;
        d.rega_idx    = w[25:21];
      end else begin
        d.uncond_branch = 1'b1;
        d.dest_idx      = w[25:21];  // link
      end
    end else if (op == JSR_GRP) begin
      d.opa_sel       = OPA_IS_NOT3;
      d.func          = ALU_AND;
      d.fu            = FU_BR;
      d.uncond_branch = 1'b1;
      d.dest_idx      = w[25:21];
      d.regb_idx      = w[20:16];
    end else begin
      bad = 1'b1;
    end
    if (bad) begin
      d.illegal = 1'b1;
      d.valid   = 1'b0;
    end
  endtask

  task automatic ref_bundle(input fetch_bundle_t b, output decoded_bundle_t e);
    for (int k = 0; k < NUM_SLOTS; k++) begin
      ref_decode(b.inst[k], b.pc + 64'(4 * k), e[k]);
    end
  endtask

  task automatic make_word(output logic [31:0] w);
    logic [31:0] r;
    logic [31:0] r2;
    logic [5:0]  op;
    logic [6:0]  fn;
    alu_func_e   f;
    logic        ok;
    r = $random(seed);
    if (rand_below(10) >= 7) begin
      w = $random(seed);  // anything at all
    end else begin
      case (rand_below(12))
        0:       w = {LDA_INST, r[25:0]};
        1:       w = {LDQ_INST, r[25:0]};
        2:       w = {STQ_INST, r[25:0]};
        3:       w = {(r[26] ? BSR_INST : BR_INST), r[25:0]};
        4:       w = {3'b111, r[28:0]};  // conditional branches
        5:       w = {JSR_GRP, r[25:0]};
        6:       w = {PAL_INST, PAL_WHAMI};
        7:       w = {PAL_INST, r[25:0]};
        8:       w = {4'b0100, r[27:0]};  // operate group, any function
        default: begin
          ok = 1'b0;
          op = INTA_GRP;
          fn = ADDQ_INST;
          for (int t = 0; t < 1000 && !ok; t++) begin
            r2 = $random(seed);
            op = {4'b0100, r2[1:0]};
            fn = r2[8:2];
            group_func(op, fn, f, ok);
          end
          w = {op, r[25:13], r[31], fn, r[4:0]};  // r[31] picks literal form
        end
      endcase
    end
  endtask

  task automatic build_bundle(output fetch_bundle_t b);
    logic [31:0] w;
    int          halt_slot;
    b.pc      = {$random(seed), $random(seed)};
    b.pc[1:0] = 2'b00;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      make_word(w);
      b.inst[k] = w;
    end
    if (halt_pending) begin
      halt_slot         = rand_below(NUM_SLOTS);
      b.inst[halt_slot] = {PAL_INST, PAL_HALT};
      halt_pending      = 1'b0;
    end
  endtask

  // valid and data stay put until the transfer
  task automatic drive_inputs();
    if (!fetch_valid || fetch_fire) begin
      if (rand_below(4) != 0) begin
        build_bundle(fetch_bundle);
        fetch_valid = 1'b1;
      end else begin
        fetch_valid = 1'b0;
      end
    end
    disp_ready = (rand_below(3) != 0);
  endtask

  // at the falling edge, values equal those at the coming rising edge
  task automatic sample_outputs();
    decoded_bundle_t exp;
    int              held;
    held       = exp_q.size() - (disp_valid ? 1 : 0);
    fetch_fire = fetch_valid & fetch_ready;
    check_bit("fetch_ready", held != QUEUE_DEPTH, fetch_ready);
    if (halt_gone) check_bit("disp_valid", 1'b0, disp_valid);
    if (disp_valid && disp_ready) begin
      if (exp_q.size() == 0) abort_run("a bundle was dispatched that was never accepted");
      exp = exp_q.pop_front();
      for (int k = 0; k < NUM_SLOTS; k++) begin
        check_addr($sformatf("disp_bundle[%0d].pc", k), exp[k].pc, disp_bundle[k].pc);
        check_addr($sformatf("disp_bundle[%0d].npc", k), exp[k].npc, disp_bundle[k].npc);
        check_addr($sformatf("disp_bundle[%0d].target", k), exp[k].target,
                   disp_bundle[k].target);
        check_decoded($sformatf("disp_bundle[%0d]", k), exp[k], disp_bundle[k]);
        if (exp[k].halt) halt_gone = 1'b1;
      end
    end
    if (fetch_fire) begin
      ref_bundle(fetch_bundle, exp);
      exp_q.push_back(exp);
      if (halt_accepted) after_halt++;
      for (int k = 0; k < NUM_SLOTS; k++) begin
        if (exp[k].halt) halt_accepted = 1'b1;
      end
    end
  endtask

  task automatic step_cycle();
    @(posedge clock);
    #1;
    drive_inputs();
    @(negedge clock);
    sample_outputs();
  endtask

  initial begin
    seed          = 32'hcc0a;
    arst_n        = 1'b0;
    fetch_valid   = 1'b0;
    fetch_bundle  = '0;
    disp_ready    = 1'b0;
    fetch_fire    = 1'b0;
    halt_pending  = 1'b0;
    halt_accepted = 1'b0;
    halt_gone     = 1'b0;
    after_halt    = 0;
    waited        = 0;
    repeat (2) @(posedge clock);
    #1 arst_n = 1'b1;
    @(negedge clock);
    check_bit("fetch_ready", 1'b1, fetch_ready);
    check_bit("disp_valid", 1'b0, disp_valid);

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      step_cycle();
    end

    // final phase, halt then the queue must fill
    halt_pending = 1'b1;
    while (!halt_gone) begin
      if (waited == WAIT_LIMIT) abort_run("timeout waiting for the halt bundle to dispatch");
      step_cycle();
      waited++;
    end
    waited = 0;
    while (fetch_ready) begin
      if (waited == WAIT_LIMIT) abort_run("timeout waiting for fetch_ready to fall after halt");
      step_cycle();
      waited++;
    end
    if (after_halt > QUEUE_DEPTH) begin
      abort_run("more bundles were accepted after halt than the queue can hold");
    end
    repeat (40) step_cycle();  // disp_valid must stay low

    $display("Everything OK");
    $finish;
  end

endmodule
